/* src/dmem_params.svh */
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// width of one data bus word
`define DMEM_DATA_WIDTH 32

`define DMEM_PIPE_DEPTH 2 // 1 puts the response stage in the request cycle

`define DMEM_LINE_WORDS 4 // granularity of the emulated cache lines

`define DMEM_WORDS 8192 // both buses share this array

`define DMEM_MISS_PENALTY 5 // stall cycles after the first miss cycle

`endif

/* src/dmem_pkg.sv */
`include "dmem_params.svh"

package dmem_pkg;

	// one bus word with lanes numbered from the low byte up
	typedef logic [`DMEM_DATA_WIDTH-1:0] word_t;

	typedef logic [31:0] addr_t; // byte address as issued by the pipeline

	typedef logic [`DMEM_DATA_WIDTH/8-1:0] byteen_t; // one bit per byte lane

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} acc_size_t;

endpackage

/* src/mem_access_unit.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module mem_access_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  logic                store,
	input  dmem_pkg::acc_size_t size,
	input  logic                load_unsigned,
	input  dmem_pkg::addr_t     address,
	input  dmem_pkg::word_t     store_data,
	input  logic                stall_in,
	output dmem_pkg::word_t     load_data,
	output logic                load_valid,
	output logic                c_read,
	output logic                c_write,
	output dmem_pkg::addr_t     c_address,
	output dmem_pkg::byteen_t   c_byteenable,
	output dmem_pkg::word_t     c_wrdata,
	input  dmem_pkg::word_t     c_rddata,
	output logic                u_read,
	output logic                u_write,
	output dmem_pkg::addr_t     u_address,
	output dmem_pkg::byteen_t   u_byteenable,
	output dmem_pkg::word_t     u_wrdata,
	input  dmem_pkg::word_t     u_rddata
);

	logic                uncached;
	dmem_pkg::byteen_t   byteen;
	dmem_pkg::word_t     lane_data;
	dmem_pkg::addr_t     word_address;

	logic                trk_load;
	logic                trk_uncached;
	logic [1:0]          trk_offset;
	dmem_pkg::acc_size_t trk_size;
	logic                trk_unsigned;

	dmem_pkg::word_t     ret_word;
	dmem_pkg::word_t     shifted;

	assign uncached     = address[29]; // uncached window of the address map
	assign word_address = {address[31:2], 2'b00};

	always_comb begin
		case (size)
			dmem_pkg::size_byte: begin
				byteen    = dmem_pkg::byteen_t'(1) << address[1:0];
				lane_data = {(`DMEM_DATA_WIDTH/8){store_data[7:0]}};
			end
			dmem_pkg::size_half: begin
				byteen    = dmem_pkg::byteen_t'(3) << {address[1], 1'b0};
				lane_data = {(`DMEM_DATA_WIDTH/16){store_data[15:0]}};
			end
			default: begin
				byteen    = '1;
				lane_data = store_data;
			end
		endcase
	end

	// the fields are shared and only the strobes tell the buses apart
	assign c_read       = req & ~store & ~uncached;
	assign c_write      = req & store & ~uncached;
	assign u_read       = req & ~store & uncached;
	assign u_write      = req & store & uncached;
	assign c_address    = word_address;
	assign u_address    = word_address;
	assign c_byteenable = byteen;
	assign u_byteenable = byteen;
	assign c_wrdata     = lane_data;
	assign u_wrdata     = lane_data;

	generate if (`DMEM_PIPE_DEPTH == 1) begin : g_track_bypass
		assign trk_load     = req & ~store;
		assign trk_uncached = uncached;
		assign trk_offset   = address[1:0];
		assign trk_size     = size;
		assign trk_unsigned = load_unsigned;
	end else begin : g_track_reg
		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				trk_load <= 1'b0;
			end else if (~stall_in) begin
				trk_load <= req & ~store; // follows the memory's pipe stage
			end
		end

		always_ff @(posedge clk) begin
			if (~stall_in) begin
				trk_uncached <= uncached;
				trk_offset   <= address[1:0];
				trk_size     <= size;
				trk_unsigned <= load_unsigned;
			end
		end
	end
	endgenerate

	always_comb begin
		ret_word = trk_uncached ? u_rddata : c_rddata;
		case (trk_size)
			dmem_pkg::size_byte: begin
				shifted   = ret_word >> {trk_offset, 3'b000}; // addressed bytes down to lane 0
				load_data = {{(`DMEM_DATA_WIDTH-8){~trk_unsigned & shifted[7]}}, shifted[7:0]};
			end
			dmem_pkg::size_half: begin
				shifted   = ret_word >> {trk_offset[1], 4'b0000};
				load_data = {{(`DMEM_DATA_WIDTH-16){~trk_unsigned & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				shifted   = ret_word;
				load_data = shifted;
			end
		endcase
	end

	assign load_valid = trk_load & ~stall_in;

endmodule

/* src/fake_dbus.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module fake_dbus (
	input  logic              clk,
	input  logic              rst,
	input  logic              fake_stall_en,
	input  logic              c_read,
	input  logic              c_write,
	input  dmem_pkg::addr_t   c_address,
	input  dmem_pkg::byteen_t c_byteenable,
	input  dmem_pkg::word_t   c_wrdata,
	output dmem_pkg::word_t   c_rddata,
	output logic              c_stall,
	input  logic              u_read,
	input  logic              u_write,
	input  dmem_pkg::addr_t   u_address,
	input  dmem_pkg::byteen_t u_byteenable,
	input  dmem_pkg::word_t   u_wrdata,
	output dmem_pkg::word_t   u_rddata,
	output logic              u_stall
);

	localparam int INDEX_BITS = $clog2(`DMEM_WORDS);
	localparam int LINE_BITS  = $clog2(`DMEM_LINE_WORDS);
	localparam int LINES      = `DMEM_WORDS / `DMEM_LINE_WORDS;
	localparam logic [`DMEM_MISS_PENALTY-1:0] PENALTY_START =
		`DMEM_MISS_PENALTY'(1) << (`DMEM_MISS_PENALTY - 1);

	dmem_pkg::word_t mem [`DMEM_WORDS];
	logic [LINES-1:0] touched;
	logic [`DMEM_MISS_PENALTY-1:0] penalty;

	logic              in_uncached;
	dmem_pkg::addr_t   in_address;
	dmem_pkg::byteen_t in_byteen;
	dmem_pkg::word_t   in_wrdata;

	logic              st_c_read;
	logic              st_c_write;
	logic              st_u_read;
	logic              st_u_write;
	dmem_pkg::addr_t   st_address;
	dmem_pkg::byteen_t st_byteen;
	dmem_pkg::word_t   st_wrdata;

	logic [INDEX_BITS-1:0]           word_idx;
	logic [INDEX_BITS-LINE_BITS-1:0] line_idx;
	logic            st_read;
	logic            st_write;
	logic            st_access;
	logic            miss;
	logic            stall_core;
	dmem_pkg::word_t old_word;
	dmem_pkg::word_t merged;

	// the request fields come from whichever bus carries the strobe
	assign in_uncached = u_read | u_write;
	assign in_address  = in_uncached ? u_address : c_address;
	assign in_byteen   = in_uncached ? u_byteenable : c_byteenable;
	assign in_wrdata   = in_uncached ? u_wrdata : c_wrdata;

	generate if (`DMEM_PIPE_DEPTH == 1) begin : g_stage_bypass
		assign st_c_read  = c_read;
		assign st_c_write = c_write;
		assign st_u_read  = u_read;
		assign st_u_write = u_write;
		assign st_address = in_address;
		assign st_byteen  = in_byteen;
		assign st_wrdata  = in_wrdata;
	end else begin : g_stage_reg
		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				st_c_read  <= 1'b0;
				st_c_write <= 1'b0;
				st_u_read  <= 1'b0;
				st_u_write <= 1'b0;
			end else if (~(c_stall | u_stall)) begin
				st_c_read  <= c_read;
				st_c_write <= c_write;
				st_u_read  <= u_read;
				st_u_write <= u_write;
			end
		end

		always_ff @(posedge clk) begin
			if (~(c_stall | u_stall)) begin
				st_address <= in_address;
				st_byteen  <= in_byteen;
				st_wrdata  <= in_wrdata;
			end
		end
	end
	endgenerate

	// upper address bits are dropped so the two regions alias
	assign word_idx  = st_address[INDEX_BITS+1:2];
	assign line_idx  = st_address[INDEX_BITS+1:LINE_BITS+2];
	assign st_read   = st_c_read | st_u_read;
	assign st_write  = st_c_write | st_u_write;
	assign st_access = st_read | st_write;
	assign old_word  = mem[word_idx];

	always_comb begin
		for (int i = 0; i < `DMEM_DATA_WIDTH/8; i++) begin
			merged[i*8 +: 8] = st_byteen[i] ? st_wrdata[i*8 +: 8] : old_word[i*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (st_write) begin
			mem[word_idx] <= merged;
		end
	end

	assign miss = st_access & ~touched[line_idx];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			touched <= '0;
		end else if (st_access) begin
			touched[line_idx] <= 1'b1;
		end
	end

	// only read misses start the penalty so a store miss leaves no stall behind
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			penalty <= '0;
		end else if (~fake_stall_en) begin
			penalty <= '0;
		end else if (miss & st_read & ~(|penalty)) begin
			penalty <= PENALTY_START;
		end else begin
			penalty <= penalty >> 1;
		end
	end

	assign stall_core = (miss | (|penalty)) & fake_stall_en;
	assign c_stall    = stall_core & st_c_read;
	assign u_stall    = stall_core & st_u_read;
	assign c_rddata   = st_c_read ? old_word : '0;
	assign u_rddata   = st_u_read ? old_word : '0;

endmodule

/* src/dmem_subsystem.sv */
`timescale 1ns/1ps

module dmem_subsystem (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  logic                store,
	input  dmem_pkg::acc_size_t size,
	input  logic                load_unsigned,
	input  dmem_pkg::addr_t     address,
	input  dmem_pkg::word_t     store_data,
	input  logic                fake_stall_en,
	output dmem_pkg::word_t     load_data,
	output logic                load_valid,
	output logic                stall
);

	logic              c_read;
	logic              c_write;
	dmem_pkg::addr_t   c_address;
	dmem_pkg::byteen_t c_byteenable;
	dmem_pkg::word_t   c_wrdata;
	dmem_pkg::word_t   c_rddata;
	logic              c_stall;

	logic              u_read;
	logic              u_write;
	dmem_pkg::addr_t   u_address;
	dmem_pkg::byteen_t u_byteenable;
	dmem_pkg::word_t   u_wrdata;
	dmem_pkg::word_t   u_rddata;
	logic              u_stall;

	assign stall = c_stall | u_stall; // either bus holds the whole pipeline

	mem_access_unit u_mau (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.store        (store),
		.size         (size),
		.load_unsigned(load_unsigned),
		.address      (address),
		.store_data   (store_data),
		.stall_in     (stall),
		.load_data    (load_data),
		.load_valid   (load_valid),
		.c_read       (c_read),
		.c_write      (c_write),
		.c_address    (c_address),
		.c_byteenable (c_byteenable),
		.c_wrdata     (c_wrdata),
		.c_rddata     (c_rddata),
		.u_read       (u_read),
		.u_write      (u_write),
		.u_address    (u_address),
		.u_byteenable (u_byteenable),
		.u_wrdata     (u_wrdata),
		.u_rddata     (u_rddata)
	);

	fake_dbus u_mem (
		.clk          (clk),
		.rst          (rst),
		.fake_stall_en(fake_stall_en),
		.c_read       (c_read),
		.c_write      (c_write),
		.c_address    (c_address),
		.c_byteenable (c_byteenable),
		.c_wrdata     (c_wrdata),
		.c_rddata     (c_rddata),
		.c_stall      (c_stall),
		.u_read       (u_read),
		.u_write      (u_write),
		.u_address    (u_address),
		.u_byteenable (u_byteenable),
		.u_wrdata     (u_wrdata),
		.u_rddata     (u_rddata),
		.u_stall      (u_stall)
	);

endmodule

/* dv/tb_dmem.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module tb_dmem;

	localparam int HALF_PERIOD = 4;
	localparam int RAND_WORDS  = 16;
	localparam int RAND_OPS    = 48;
	localparam logic [31:0] RAND_BASE = 32'h0000_1000; // clear of the directed addresses

	typedef struct packed {
		logic [3:0]  op;
		logic [1:0]  size;
		logic        uns;
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] exp_data;
	} pattern_t;

	logic                clk;
	logic                rst;
	logic                req;
	logic                store;
	dmem_pkg::acc_size_t size;
	logic                load_unsigned;
	dmem_pkg::addr_t     address;
	dmem_pkg::word_t     store_data;
	logic                fake_stall_en;
	dmem_pkg::word_t     load_data;
	logic                load_valid;
	logic                stall;

	pattern_t   patterns[$];
	bit         patterns_ready;
	bit         touched_lines[int]; // lines the memory has seen since the last reset
	logic [7:0] shadow[int]; // byte image of the random region
	integer     seed;

	dmem_subsystem dut (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.store        (store),
		.size         (size),
		.load_unsigned(load_unsigned),
		.address      (address),
		.store_data   (store_data),
		.fake_stall_en(fake_stall_en),
		.load_data    (load_data),
		.load_valid   (load_valid),
		.stall        (stall)
	);

	always #HALF_PERIOD clk = ~clk;

	task automatic abort(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %s got %h expected %h", name, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic read_patterns();
		int          fd;
		int          fields;
		string       text;
		logic [31:0] op_v;
		logic [31:0] size_v;
		logic [31:0] uns_v;
		logic [31:0] addr_v;
		logic [31:0] data_v;
		logic [31:0] exp_v;
		pattern_t    p;
		fd = $fopen("dv/dmem_patterns.txt", "r");
		if (fd == 0) begin
			abort("cannot open dv/dmem_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				void'($fgets(text, fd));
				if (text.len() > 0 && text.getc(0) != "#") begin
					fields = $sscanf(text, "%h %h %h %h %h %h",
						op_v, size_v, uns_v, addr_v, data_v, exp_v);
					if (fields == 6) begin
						p.op       = op_v[3:0];
						p.size     = size_v[1:0];
						p.uns      = uns_v[0];
						p.address  = addr_v;
						p.data     = data_v;
						p.exp_data = exp_v;
						patterns.push_back(p);
					end
				end
			end
			$fclose(fd);
			patterns_ready = 1'b1;
		end
	endtask

	// rst is also asserted here so the first call at time zero gives the power-up reset
	task automatic apply_reset();
		rst = 1'b1;
		req = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		touched_lines.delete();
		check_value("stall", {31'b0, stall}, 32'd0);
		check_value("load_valid", {31'b0, load_valid}, 32'd0);
	endtask

	task automatic set_stall_en(input bit en);
		@(negedge clk); // one idle cycle empties the response stage
		fake_stall_en = en;
	endtask

	task automatic run_access(input bit st, input logic [1:0] sz, input bit uns,
			input logic [31:0] addr, input logic [31:0] data, input logic [31:0] expected);
		int stall_cycles;
		int line_no;
		int exp_stall;
		stall_cycles = 0;
		line_no      = ((addr >> 2) % `DMEM_WORDS) / `DMEM_LINE_WORDS;
		exp_stall    = 0;
		if (!st && fake_stall_en && !touched_lines.exists(line_no)) begin
			exp_stall = 1 + `DMEM_MISS_PENALTY; // first read of a line pays the miss
		end
		touched_lines[line_no] = 1'b1;
		req           = 1'b1;
		store         = st;
		size          = dmem_pkg::acc_size_t'(sz);
		load_unsigned = uns;
		address       = addr;
		store_data    = data;
		while (stall) @(negedge clk); // request held until the memory takes it
		@(negedge clk);
		req = 1'b0;
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		check_value("stall cycles", stall_cycles, exp_stall);
		check_value("load_valid", {31'b0, load_valid}, st ? 32'd0 : 32'd1);
		if (!st) begin
			check_value("load_data", load_data, expected);
		end
	endtask

	task automatic random_phase();
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expected;
		logic [1:0]  sz;
		int          word;
		int          off;
		bit          st;
		bit          uns;
		for (int w = 0; w < RAND_WORDS; w++) begin
			data = $random(seed);
			for (int k = 0; k < 4; k++) shadow[w * 4 + k] = data[k * 8 +: 8];
			run_access(1'b1, 2'd2, 1'b0, RAND_BASE + w * 4, data, 32'h0);
		end
		apply_reset();
		set_stall_en(1'b1);
		for (int n = 0; n < RAND_OPS; n++) begin
			r = $random(seed);
			if (r[3:0] == 4'd0) set_stall_en(~fake_stall_en);
			repeat ((r >> 4) & 3) @(negedge clk);
			st   = r[6];
			uns  = r[7];
			sz   = (r[9:8] == 2'd3) ? 2'd2 : r[9:8];
			word = (r >> 10) & 15;
			off  = 0;
			if (sz == 2'd0) off = (r >> 14) & 3;
			if (sz == 2'd1) off = (r >> 14) & 2;
			addr        = RAND_BASE + word * 4 + ((r >> 14) & 3); // low bits past the size are ignored
			addr[29]    = r[16]; // region choice
			addr[28:15] = r[30:17]; // bits the memory ignores
			data        = $random(seed);
			expected    = 32'h0;
			for (int k = 0; k < (1 << sz); k++) begin
				if (st) shadow[word * 4 + off + k] = data[k * 8 +: 8];
				else expected[k * 8 +: 8] = shadow[word * 4 + off + k];
			end
			if (!uns && sz == 2'd0) expected = {{24{expected[7]}}, expected[7:0]};
			if (!uns && sz == 2'd1) expected = {{16{expected[15]}}, expected[15:0]};
			run_access(st, sz, uns, addr, data, expected);
		end
	endtask

	initial begin
		wait (patterns_ready);
		repeat ((patterns.size() + 64) * 12) @(posedge clk);
		abort("timeout, the test did not finish in the allowed number of cycles");
	end

	initial begin
		seed          = 32'h444c_f139;
		clk           = 1'b0;
		rst           = 1'b1;
		req           = 1'b0;
		store         = 1'b0;
		size          = dmem_pkg::size_byte;
		load_unsigned = 1'b0;
		address       = '0;
		store_data    = '0;
		fake_stall_en = 1'b0;
		read_patterns();
		apply_reset();
		foreach (patterns[i]) begin
			case (patterns[i].op)
				4'd0, 4'd1: run_access(patterns[i].op == 4'd0, patterns[i].size,
					patterns[i].uns, patterns[i].address, patterns[i].data,
					patterns[i].exp_data);
				4'd2: apply_reset();
				4'd3: set_stall_en(patterns[i].data[0]);
				default: abort("unknown operation code in the patterns file");
			endcase
		end
		random_phase();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* src.f */
+incdir+src
src/dmem_pkg.sv
src/mem_access_unit.sv
src/fake_dbus.sv
src/dmem_subsystem.sv
dv/tb_dmem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_dmem
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with $(TOOL) and run it"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/dmem_patterns.txt */
# op size uns address data expect, all fields in hex
# op 0 store, 1 load, 2 reset, 3 fake_stall_en from data bit 0; size 0 byte, 1 half, 2 word
3 0 0 00000000 00000000 00000000
0 2 0 00000100 a1b2c3d4 00000000
1 2 0 00000100 00000000 a1b2c3d4
0 2 0 20000200 13572468 00000000
1 2 0 20000200 00000000 13572468
0 2 0 00000104 0badf00d 00000000
1 2 0 00000104 00000000 0badf00d
1 2 0 00000100 00000000 a1b2c3d4
# the two regions alias on the low address bits
1 2 0 00000200 00000000 13572468
1 2 0 20000100 00000000 a1b2c3d4
1 2 0 3fff8104 00000000 0badf00d
# partial stores merge into an existing word
0 2 0 00000300 11223344 00000000
0 0 0 00000301 123456ab 00000000
0 1 0 00000302 9876f00d 00000000
1 2 0 00000300 00000000 f00dab44
1 0 0 00000300 00000000 00000044
1 0 0 00000301 00000000 ffffffab
1 0 1 00000301 00000000 000000ab
1 0 0 00000302 00000000 0000000d
1 0 0 00000303 00000000 fffffff0
1 0 1 00000303 00000000 000000f0
1 1 0 00000300 00000000 ffffab44
1 1 1 00000300 00000000 0000ab44
1 1 0 00000302 00000000 fffff00d
1 1 1 00000302 00000000 0000f00d
0 0 0 20000300 ffffff55 00000000
0 1 0 20000206 00007fff 00000000
1 2 0 00000300 00000000 f00dab55
1 1 0 20000206 00000000 00007fff
1 0 0 00000207 00000000 0000007f
# miss emulation, reset forgets the touched lines but keeps the contents
3 0 0 00000000 00000001 00000000
2 0 0 00000000 00000000 00000000
1 2 0 00000100 00000000 a1b2c3d4
1 2 0 00000104 00000000 0badf00d
1 2 0 20000100 00000000 a1b2c3d4
0 2 0 00000304 cafebabe 00000000
1 2 0 00000300 00000000 f00dab55
1 2 0 00000304 00000000 cafebabe
1 1 1 20000202 00000000 00001357
1 0 0 00000200 00000000 00000068
# without stall emulation no load waits
3 0 0 00000000 00000000 00000000
2 0 0 00000000 00000000 00000000
1 2 0 00000100 00000000 a1b2c3d4
1 2 0 20000300 00000000 f00dab55
1 0 0 00000206 00000000 ffffffff
1 0 1 20000206 00000000 000000ff
